/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mem_sys \
      -o tb_mem_sys \
   && ./obj_dir/tb_mem_sys || exit 1

/* source/axi_burst_master.sv */
`include "mem_sys_params.svh"

module axi_burst_master (
   input  logic               Clk,
   input  logic               arst_n_i,
   rd_burst_if.slave          rd,
   wr_burst_if.slave          wr,
   // Read address and data
   output mem_sys_pkg::addr_t m_axi_araddr_o,
   output logic [7:0]         m_axi_arlen_o,
   output logic               m_axi_arvalid_o,
   input  logic               m_axi_arready_i,
   input  mem_sys_pkg::word_t m_axi_rdata_i,
   input  logic               m_axi_rlast_i,
   input  logic               m_axi_rvalid_i,
   output logic               m_axi_rready_o,
   // Write address, data and response
   output mem_sys_pkg::addr_t m_axi_awaddr_o,
   output logic [7:0]         m_axi_awlen_o,
   output logic               m_axi_awvalid_o,
   input  logic               m_axi_awready_i,
   output mem_sys_pkg::word_t m_axi_wdata_o,
   output logic               m_axi_wlast_o,
   output logic               m_axi_wvalid_o,
   input  logic               m_axi_wready_i,
   input  logic               m_axi_bvalid_i,
   output logic               m_axi_bready_o
);
   import mem_sys_pkg::*;

   rd_state_e             rd_state_q;
   wr_state_e             wr_state_q;
   addr_t                 araddr_q;
   addr_t                 awaddr_q;
   logic [`MS_BEAT_W-1:0] wcnt_q;

   ////////////////////////////////////////////////////////////
   // Read channel
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_state_q <= RD_IDLE;
      end else begin
         case (rd_state_q)
            RD_IDLE: if (rd.req) rd_state_q <= RD_ADDR;
            RD_ADDR: if (m_axi_arready_i) rd_state_q <= RD_DATA;
            RD_DATA: if (m_axi_rvalid_i && m_axi_rlast_i) rd_state_q <= RD_IDLE;
            default: rd_state_q <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge Clk) begin
      if ((rd_state_q == RD_IDLE) && rd.req) araddr_q <= {rd.line_addr, {`MS_OFS_W{1'b0}}};
   end

   assign m_axi_araddr_o  = araddr_q;
   assign m_axi_arlen_o   = 8'(`MS_LINE_WORDS - 1);
   assign m_axi_arvalid_o = (rd_state_q == RD_ADDR);
   assign m_axi_rready_o  = (rd_state_q == RD_DATA);   // Never refuses a beat

   assign rd.beat_valid = m_axi_rready_o && m_axi_rvalid_i;
   assign rd.beat_data  = m_axi_rdata_i;
   assign rd.beat_last  = m_axi_rlast_i;

   ////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_state_q <= WR_IDLE;
         wcnt_q     <= '0;
      end else begin
         case (wr_state_q)
            WR_IDLE: if (wr.req) wr_state_q <= WR_ADDR;
            WR_ADDR: begin
               if (m_axi_awready_i) begin
                  wr_state_q <= WR_DATA;
                  wcnt_q     <= '0;
               end
            end
            WR_DATA: begin
               if (m_axi_wready_i) begin
                  wcnt_q <= wcnt_q + 1'b1;
                  if (m_axi_wlast_o) wr_state_q <= WR_RESP;
               end
            end
            WR_RESP: if (m_axi_bvalid_i) wr_state_q <= WR_IDLE;  // Response not inspected
            default: wr_state_q <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge Clk) begin
      if ((wr_state_q == WR_IDLE) && wr.req) awaddr_q <= {wr.line_addr, {`MS_OFS_W{1'b0}}};
   end

   assign m_axi_awaddr_o  = awaddr_q;
   assign m_axi_awlen_o   = 8'(`MS_LINE_WORDS - 1);
   assign m_axi_awvalid_o = (wr_state_q == WR_ADDR);
   assign m_axi_wvalid_o  = (wr_state_q == WR_DATA);
   assign m_axi_wdata_o   = wr.beat_data;
   assign m_axi_wlast_o   = m_axi_wvalid_o && (wcnt_q == `MS_BEAT_W'(`MS_LINE_WORDS - 1));
   assign m_axi_bready_o  = (wr_state_q == WR_RESP);

   assign wr.beat_take = m_axi_wvalid_o && m_axi_wready_i;
   assign wr.done      = m_axi_bready_o && m_axi_bvalid_i;

endmodule

/* source/dcache.sv */
`include "mem_sys_params.svh"

module dcache (
   input  logic               Clk,
   input  logic               arst_n_i,
   input  logic               req_en_i,
   input  logic               req_we_i,
   input  mem_sys_pkg::addr_t req_addr_i,
   input  mem_sys_pkg::word_t req_wdata_i,
   output mem_sys_pkg::word_t req_rdata_o,
   output logic               stall_o,
   line_fill_if.master        fill,
   line_write_if.master       evict
);
   import mem_sys_pkg::*;

   // Storage
   logic [`MS_NUM_SETS-1:0] valid_q;
   logic [`MS_NUM_SETS-1:0] dirty_q;
   tag_t                    tag_q  [`MS_NUM_SETS];
   line_t                   data_q [`MS_NUM_SETS];

   cache_state_e            state_q;
   logic                    load_q;
   logic                    start_q;
   line_addr_t              miss_line_q;

   logic [`MS_IDX_W-1:0]    idx;
   tag_t                    tag;
   logic [`MS_BEAT_W-1:0]   wsel;
   logic                    hit;
   logic                    wr_hit;
   logic                    miss;
   logic [`MS_IDX_W-1:0]    midx;
   tag_t                    mtag;
   logic                    need_evict;

   ////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////
   assign idx  = req_addr_i[`MS_OFS_W +: `MS_IDX_W];
   assign tag  = req_addr_i[`MS_ADDR_W-1 -: `MS_TAG_W];
   assign wsel = req_addr_i[2 +: `MS_BEAT_W];   // Bits 1:0 ignored

   assign hit    = valid_q[idx] && (tag_q[idx] == tag);
   assign wr_hit = (state_q == C_LOOKUP) && req_en_i && req_we_i && hit;
   assign miss   = (state_q == C_LOOKUP) && req_en_i && !hit;

   assign req_rdata_o = data_q[idx][wsel*`MS_WORD_W +: `MS_WORD_W];
   assign stall_o     = req_en_i && !((state_q == C_LOOKUP) && hit);

   // Set of the outstanding miss
   assign midx       = miss_line_q[`MS_IDX_W-1:0];
   assign mtag       = miss_line_q[`MS_IDX_W +: `MS_TAG_W];
   assign need_evict = valid_q[midx] && dirty_q[midx];

   assign evict.load      = load_q;
   assign evict.line_addr = {tag_q[midx], midx};
   assign evict.line      = data_q[midx];

   assign fill.start     = start_q;
   assign fill.line_addr = miss_line_q;

   ////////////////////////////////////////////////////////////
   // Miss sequencer
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= C_LOOKUP;
         valid_q <= '0;
         dirty_q <= '0;
         load_q  <= 1'b0;
         start_q <= 1'b0;
      end else begin
         load_q  <= 1'b0;
         start_q <= 1'b0;
         case (state_q)
            C_LOOKUP: begin
               if (wr_hit) begin
                  dirty_q[idx] <= 1'b1;
               end else if (miss) begin
                  state_q <= C_WAIT_WB;
               end
            end
            C_WAIT_WB: begin
               if (need_evict) begin
                  if (!evict.busy) begin
                     load_q        <= 1'b1;   // Victim now owned by write buffer
                     dirty_q[midx] <= 1'b0;
                  end
               end else if (!(evict.busy && (evict.held_addr == miss_line_q))) begin
                  // A draining copy of the missed line must reach memory first
                  start_q <= 1'b1;
                  state_q <= C_REFILL;
               end
            end
            C_REFILL: begin
               if (fill.done) begin
                  valid_q[midx] <= 1'b1;
                  dirty_q[midx] <= 1'b0;
                  state_q       <= C_LOOKUP;
               end
            end
            default: state_q <= C_LOOKUP;
         endcase
      end
   end

   // Arrays and miss address
   always_ff @(posedge Clk) begin
      if (wr_hit) begin
         data_q[idx][wsel*`MS_WORD_W +: `MS_WORD_W] <= req_wdata_i;
      end
      if (miss) begin
         miss_line_q <= req_addr_i[`MS_ADDR_W-1:`MS_OFS_W];
      end
      if ((state_q == C_REFILL) && fill.done) begin
         data_q[midx] <= fill.line;
         tag_q[midx]  <= mtag;
      end
   end

endmodule

/* source/line_fill_buf.sv */
`include "mem_sys_params.svh"

module line_fill_buf (
   input  logic        Clk,
   input  logic        arst_n_i,
   line_fill_if.slave  fill,
   rd_burst_if.master  rd
);
   import mem_sys_pkg::*;

   logic                  req_q;
   logic                  done_q;
   logic [`MS_BEAT_W-1:0] cnt_q;    // Next word slot
   line_addr_t            addr_q;
   line_t                 line_q;

   always_ff @(posedge Clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_q  <= 1'b0;
         done_q <= 1'b0;
         cnt_q  <= '0;
      end else begin
         req_q  <= fill.start;
         done_q <= rd.beat_valid && rd.beat_last;
         if (fill.start) cnt_q <= '0;
         else if (rd.beat_valid) cnt_q <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge Clk) begin
      if (fill.start) addr_q <= fill.line_addr;
      if (rd.beat_valid) line_q[cnt_q*`MS_WORD_W +: `MS_WORD_W] <= rd.beat_data;
   end

   assign rd.req       = req_q;
   assign rd.line_addr = addr_q;
   assign fill.line    = line_q;
   assign fill.done    = done_q;   // Cycle after the last beat

endmodule

/* source/line_write_buf.sv */
`include "mem_sys_params.svh"

module line_write_buf (
   input  logic        Clk,
   input  logic        arst_n_i,
   line_write_if.slave evict,
   wr_burst_if.master  wr
);
   import mem_sys_pkg::*;

   logic                  busy_q;
   logic                  req_q;
   logic [`MS_BEAT_W-1:0] cnt_q;
   line_addr_t            addr_q;
   line_t                 line_q;

   ////////////////////////////////////////////////////////////
   // Ownership of the victim line
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
         req_q  <= 1'b0;
         cnt_q  <= '0;
      end else begin
         req_q <= evict.load;
         if (evict.load) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else begin
            if (wr.done) busy_q <= 1'b0;     // Released on write response
            if (wr.beat_take) cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (evict.load) begin
         addr_q <= evict.line_addr;
         line_q <= evict.line;
      end
   end

   assign evict.busy      = busy_q;
   assign evict.held_addr = addr_q;

   assign wr.req       = req_q;
   assign wr.line_addr = addr_q;
   assign wr.beat_data = line_q[cnt_q*`MS_WORD_W +: `MS_WORD_W];

endmodule

/* source/mem_sys_ifs.sv */
////////////////////////////////////////////////////////////
// Cache to line fill buffer
////////////////////////////////////////////////////////////
interface line_fill_if;
   import mem_sys_pkg::*;
   logic       start;      // One-cycle pulse
   line_addr_t line_addr;
   line_t      line;
   logic       done;       // Line valid while high

   modport master (output start, output line_addr, input line, input done);
   modport slave  (input start, input line_addr, output line, output done);
endinterface

// Fill buffer to burst master, read side
interface rd_burst_if;
   import mem_sys_pkg::*;
   logic       req;
   line_addr_t line_addr;
   logic       beat_valid; // One per accepted R beat
   word_t      beat_data;
   logic       beat_last;

   modport master (output req, output line_addr,
                   input beat_valid, input beat_data, input beat_last);
   modport slave  (input req, input line_addr,
                   output beat_valid, output beat_data, output beat_last);
endinterface

////////////////////////////////////////////////////////////
// Cache to line write buffer
////////////////////////////////////////////////////////////
interface line_write_if;
   import mem_sys_pkg::*;
   logic       load;
   line_addr_t line_addr;
   line_t      line;
   logic       busy;
   line_addr_t held_addr;  // Line still waiting for its write response

   modport master (output load, output line_addr, output line, input busy, input held_addr);
   modport slave  (input load, input line_addr, input line, output busy, output held_addr);
endinterface

interface wr_burst_if;
   import mem_sys_pkg::*;
   logic       req;
   line_addr_t line_addr;
   word_t      beat_data;
   logic       beat_take;  // Accepted W beat
   logic       done;       // B handshake

   modport master (output req, output line_addr, output beat_data,
                   input beat_take, input done);
   modport slave  (input req, input line_addr, input beat_data,
                   output beat_take, output done);
endinterface

/* source/mem_sys_params.svh */
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// Bus and data widths
`define MS_ADDR_W      32
`define MS_WORD_W      32

// Cache geometry
`define MS_LINE_WORDS  8
`define MS_NUM_SETS    8

// Address split, tag | index | byte offset
`define MS_OFS_W       5
`define MS_IDX_W       3
`define MS_TAG_W       24
`define MS_BEAT_W      3   // Counts the words of one burst

`endif

/* source/mem_sys_pkg.sv */
`include "mem_sys_params.svh"

package mem_sys_pkg;

   typedef logic [`MS_ADDR_W-1:0]                  addr_t;
   typedef logic [`MS_WORD_W-1:0]                  word_t;
   typedef logic [`MS_LINE_WORDS*`MS_WORD_W-1:0]   line_t;      // Word 0 in low bits
   typedef logic [`MS_ADDR_W-`MS_OFS_W-1:0]        line_addr_t; // Address without offset
   typedef logic [`MS_TAG_W-1:0]                   tag_t;

   // Miss sequencer of the data cache
   typedef enum logic [1:0] {
      C_LOOKUP,
      C_WAIT_WB,
      C_REFILL
   } cache_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_e;

endpackage

/* source/mem_sys_top.sv */
module mem_sys_top (
   input  logic               Clk,
   input  logic               arst_n_i,
   // Request port
   input  logic               req_en_i,
   input  logic               req_we_i,
   input  mem_sys_pkg::addr_t req_addr_i,
   input  mem_sys_pkg::word_t req_wdata_i,
   output mem_sys_pkg::word_t req_rdata_o,
   output logic               stall_o,
   // Memory side
   output mem_sys_pkg::addr_t m_axi_araddr_o,
   output logic [7:0]         m_axi_arlen_o,
   output logic               m_axi_arvalid_o,
   input  logic               m_axi_arready_i,
   input  mem_sys_pkg::word_t m_axi_rdata_i,
   input  logic               m_axi_rlast_i,
   input  logic               m_axi_rvalid_i,
   output logic               m_axi_rready_o,
   output mem_sys_pkg::addr_t m_axi_awaddr_o,
   output logic [7:0]         m_axi_awlen_o,
   output logic               m_axi_awvalid_o,
   input  logic               m_axi_awready_i,
   output mem_sys_pkg::word_t m_axi_wdata_o,
   output logic               m_axi_wlast_o,
   output logic               m_axi_wvalid_o,
   input  logic               m_axi_wready_i,
   input  logic               m_axi_bvalid_i,
   output logic               m_axi_bready_o
);
   import mem_sys_pkg::*;

   line_fill_if  fill_if ();
   rd_burst_if   rd_if ();
   line_write_if evict_if ();
   wr_burst_if   wr_if ();

   // Lookup stage
   dcache i_dcache (
      .Clk, .arst_n_i, .req_en_i, .req_we_i, .req_addr_i, .req_wdata_i,
      .req_rdata_o, .stall_o, .fill(fill_if), .evict(evict_if)
   );

   line_fill_buf  i_line_fill_buf  (.Clk, .arst_n_i, .fill(fill_if), .rd(rd_if));
   line_write_buf i_line_write_buf (.Clk, .arst_n_i, .evict(evict_if), .wr(wr_if));

   // Bus stage
   axi_burst_master i_axi_burst_master (
      .Clk, .arst_n_i, .rd(rd_if), .wr(wr_if),
      .m_axi_araddr_o, .m_axi_arlen_o, .m_axi_arvalid_o, .m_axi_arready_i,
      .m_axi_rdata_i, .m_axi_rlast_i, .m_axi_rvalid_i, .m_axi_rready_o,
      .m_axi_awaddr_o, .m_axi_awlen_o, .m_axi_awvalid_o, .m_axi_awready_i,
      .m_axi_wdata_o, .m_axi_wlast_o, .m_axi_wvalid_o, .m_axi_wready_i,
      .m_axi_bvalid_i, .m_axi_bready_o
   );

endmodule

/* src.f */
+incdir+source
source/mem_sys_pkg.sv
source/mem_sys_ifs.sv
source/dcache.sv
source/line_fill_buf.sv
source/line_write_buf.sv
source/axi_burst_master.sv
source/mem_sys_top.sv
verif/mem_sys_props.sv
verif/tb_mem_sys.sv

/* verif/mem_sys_props.sv */
module mem_sys_props (
   input logic               Clk,
   input logic               arst_n_i,
   input logic               arvalid_i,
   input logic               arready_i,
   input mem_sys_pkg::addr_t araddr_i,
   input logic               awvalid_i,
   input logic               awready_i,
   input mem_sys_pkg::addr_t awaddr_i,
   input logic               wvalid_i,
   input logic               wlast_i
);

   // Address channels hold until accepted
   ar_hold: assert property (@(posedge Clk) disable iff (!arst_n_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
      else $error("AR valid or address changed before arready");

   aw_hold: assert property (@(posedge Clk) disable iff (!arst_n_i)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
      else $error("AW valid or address changed before awready");

   wlast_in_beat: assert property (@(posedge Clk) disable iff (!arst_n_i)
      wlast_i |-> wvalid_i)
      else $error("wlast seen without wvalid");

endmodule

bind axi_burst_master mem_sys_props i_mem_sys_props (
   .Clk(Clk), .arst_n_i(arst_n_i),
   .arvalid_i(m_axi_arvalid_o), .arready_i(m_axi_arready_i), .araddr_i(m_axi_araddr_o),
   .awvalid_i(m_axi_awvalid_o), .awready_i(m_axi_awready_i), .awaddr_i(m_axi_awaddr_o),
   .wvalid_i(m_axi_wvalid_o), .wlast_i(m_axi_wlast_o)
);

/* verif/tb_mem_sys.sv */
`include "mem_sys_params.svh"

module tb_mem_sys;
   import mem_sys_pkg::*;

   localparam int WIN_WORDS   = 256;   // 1 KiB window
   localparam int NUM_REQ     = 400;
   localparam int TIMEOUT_CYC = 300;

   logic Clk = 1'b0;
   logic arst_n_i;
   logic req_en_i;
   logic req_we_i;
   addr_t req_addr_i;
   word_t req_wdata_i;
   word_t req_rdata_o;
   logic stall_o;
   addr_t m_axi_araddr_o;
   logic [7:0] m_axi_arlen_o;
   logic m_axi_arvalid_o;
   logic m_axi_arready_i;
   word_t m_axi_rdata_i;
   logic m_axi_rlast_i;
   logic m_axi_rvalid_i;
   logic m_axi_rready_o;
   addr_t m_axi_awaddr_o;
   logic [7:0] m_axi_awlen_o;
   logic m_axi_awvalid_o;
   logic m_axi_awready_i;
   word_t m_axi_wdata_o;
   logic m_axi_wlast_o;
   logic m_axi_wvalid_o;
   logic m_axi_wready_i;
   logic m_axi_bvalid_i;
   logic m_axi_bready_o;

   // Memory contents and latest written values
   word_t mem [WIN_WORDS];
   word_t golden [WIN_WORDS];

   // Shadow of the cache directory
   logic [`MS_NUM_SETS-1:0] sh_valid;
   logic [`MS_NUM_SETS-1:0] sh_dirty;
   tag_t                    sh_tag [`MS_NUM_SETS];

   addr_t exp_ar[$];   // Predicted burst addresses
   addr_t exp_aw[$];
   int    exp_rd;
   int    exp_wr;
   int    rd_count;
   int    wr_count;

   logic [31:0] lcg_state;
   logic        nxt_we;
   addr_t       nxt_addr;
   word_t       nxt_wdata;
   bit          pred_hit;

   mem_sys_top i_mem_sys_top (.*);

   always #10 Clk = ~Clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         report_failure($sformatf("Error: %s got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp)
         report_failure($sformatf("Error: %s got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input bit got, input bit exp);
      if (got !== exp)
         report_failure($sformatf("Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // Next request and its predicted bursts
   task automatic pick_request(input bit first);
      logic [31:0]          r;
      logic [`MS_IDX_W-1:0] idx;
      tag_t                 tag;
      r         = lcg_next();
      nxt_we    = first ? 1'b0 : r[31];
      r         = lcg_next();
      nxt_addr  = {22'd0, r[31:22]};   // Low two bits left random
      nxt_wdata = lcg_next();
      idx       = nxt_addr[`MS_OFS_W +: `MS_IDX_W];
      tag       = nxt_addr[`MS_ADDR_W-1 -: `MS_TAG_W];
      pred_hit  = sh_valid[idx] && (sh_tag[idx] == tag);
      if (!pred_hit) begin
         if (sh_valid[idx] && sh_dirty[idx]) begin
            exp_aw.push_back({sh_tag[idx], idx, {`MS_OFS_W{1'b0}}});
            exp_wr++;
         end
         exp_ar.push_back({nxt_addr[`MS_ADDR_W-1:`MS_OFS_W], {`MS_OFS_W{1'b0}}});
         exp_rd++;
         sh_valid[idx] = 1'b1;
         sh_tag[idx]   = tag;
         sh_dirty[idx] = 1'b0;
      end
      if (nxt_we) sh_dirty[idx] = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // Memory slave
   ////////////////////////////////////////////////////////////
   initial begin : memory_slave
      logic [31:0] r;
      logic [7:0]  wi;
      addr_t       rd_base;
      addr_t       wr_base;
      int          rd_beat;
      int          wr_beat;
      bit          rd_active;
      bit          b_pending;
      m_axi_arready_i = 1'b0;
      m_axi_rdata_i   = '0;
      m_axi_rlast_i   = 1'b0;
      m_axi_rvalid_i  = 1'b0;
      m_axi_awready_i = 1'b0;
      m_axi_wready_i  = 1'b0;
      m_axi_bvalid_i  = 1'b0;
      rd_base   = '0;
      wr_base   = '0;
      rd_beat   = 0;
      wr_beat   = 0;
      rd_active = 1'b0;
      b_pending = 1'b0;
      forever begin
         @(negedge Clk);   // Handshakes of the coming edge
         if (m_axi_arvalid_o && m_axi_arready_i) begin
            if (exp_ar.size() == 0) report_failure("Read burst issued with no miss pending");
            check_addr("m_axi_araddr_o", m_axi_araddr_o, exp_ar.pop_front());
            check_word("m_axi_arlen_o", word_t'(m_axi_arlen_o), word_t'(`MS_LINE_WORDS - 1));
            rd_base   = m_axi_araddr_o;
            rd_beat   = 0;
            rd_active = 1'b1;
            rd_count++;
         end
         if (m_axi_rvalid_i && m_axi_rready_o) begin
            rd_beat++;
            if (m_axi_rlast_i) rd_active = 1'b0;
         end
         if (m_axi_awvalid_o && m_axi_awready_i) begin
            if (exp_aw.size() == 0) report_failure("Write burst issued with no eviction pending");
            check_addr("m_axi_awaddr_o", m_axi_awaddr_o, exp_aw.pop_front());
            check_word("m_axi_awlen_o", word_t'(m_axi_awlen_o), word_t'(`MS_LINE_WORDS - 1));
            wr_base = m_axi_awaddr_o;
            wr_beat = 0;
         end
         if (m_axi_wvalid_o && m_axi_wready_i) begin
            wi = wr_base[9:2] + 8'(wr_beat);
            check_word("m_axi_wdata_o", m_axi_wdata_o, golden[wi]);
            check_flag("m_axi_wlast_o", m_axi_wlast_o, wr_beat == `MS_LINE_WORDS - 1);
            mem[wi] = m_axi_wdata_o;
            wr_beat++;
            if (wr_beat == `MS_LINE_WORDS) b_pending = 1'b1;
         end
         if (m_axi_bvalid_i && m_axi_bready_o) begin
            b_pending = 1'b0;
            wr_count++;
         end
         @(posedge Clk);
         #1;
         r = lcg_next();
         m_axi_arready_i = r[31] | r[30];   // Ready about three cycles in four
         m_axi_awready_i = r[29] | r[28];
         m_axi_wready_i  = r[27] | r[26];
         m_axi_rvalid_i  = rd_active;
         m_axi_rdata_i   = mem[rd_base[9:2] + 8'(rd_beat)];
         m_axi_rlast_i   = rd_active && (rd_beat == `MS_LINE_WORDS - 1);
         m_axi_bvalid_i  = b_pending;
      end
   end

   ////////////////////////////////////////////////////////////
   // Requests and checks
   ////////////////////////////////////////////////////////////
   initial begin : stimulus
      int n;
      int i;
      int cycles;
      arst_n_i    = 1'b0;
      req_en_i    = 1'b0;
      req_we_i    = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      lcg_state   = 32'd28;
      sh_valid    = '0;
      sh_dirty    = '0;
      exp_rd      = 0;
      exp_wr      = 0;
      rd_count    = 0;
      wr_count    = 0;
      for (i = 0; i < WIN_WORDS; i++) begin
         mem[i]    = (word_t'(i * 4) * 32'h9E3779B1) ^ 32'h5A5A0000;
         golden[i] = mem[i];
      end
      repeat (16) @(posedge Clk);
      #1 arst_n_i = 1'b1;
      @(negedge Clk);
      check_flag("stall_o", stall_o, 1'b0);
      check_flag("m_axi_arvalid_o", m_axi_arvalid_o, 1'b0);
      check_flag("m_axi_rready_o", m_axi_rready_o, 1'b0);
      check_flag("m_axi_awvalid_o", m_axi_awvalid_o, 1'b0);
      check_flag("m_axi_wvalid_o", m_axi_wvalid_o, 1'b0);
      check_flag("m_axi_bready_o", m_axi_bready_o, 1'b0);
      @(posedge Clk);
      for (n = 0; n < NUM_REQ; n++) begin
         pick_request(n == 0);
         #1;
         req_en_i    = 1'b1;
         req_we_i    = nxt_we;
         req_addr_i  = nxt_addr;
         req_wdata_i = nxt_wdata;
         @(negedge Clk);
         check_flag("stall_o", stall_o, !pred_hit);   // Hits never stall
         cycles = 0;
         while (stall_o) begin
            if (cycles == TIMEOUT_CYC) report_failure("Timeout: request never completed");
            cycles++;
            @(negedge Clk);
         end
         if (!nxt_we) check_word("req_rdata_o", req_rdata_o, golden[nxt_addr[9:2]]);
         check_word("read burst count", word_t'(rd_count), word_t'(exp_rd));
         @(posedge Clk);
         if (nxt_we) golden[nxt_addr[9:2]] = nxt_wdata;
      end
      #1 req_en_i = 1'b0;
      // Let the last eviction drain
      cycles = 0;
      @(negedge Clk);
      while (m_axi_awvalid_o || m_axi_wvalid_o || m_axi_bready_o) begin
         if (cycles == TIMEOUT_CYC) report_failure("Timeout: last write burst never finished");
         cycles++;
         @(negedge Clk);
      end
      check_word("read burst count", word_t'(rd_count), word_t'(exp_rd));
      check_word("write burst count", word_t'(wr_count), word_t'(exp_wr));
      if (exp_ar.size() != 0 || exp_aw.size() != 0) begin
         report_failure("Predicted bursts were never issued");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule
